/* hw/eepromPkg.sv */
// Shared types and constants for the SPI EEPROM controller.
// Holds the host request codes, the 25xx instruction bytes and the
// status register layout. RTL and testbench pull it in with a
// wildcard import.

`default_nettype none

package eepromPkg;

    // host request, sampled together with start
    typedef enum logic [1:0]
    {
        REQ_READ   = 2'd0,
        REQ_WRITE  = 2'd1,
        REQ_STATUS = 2'd2
    } eepromReq_t;

    // instruction bytes of a 25xx part with 8-bit addressing
    typedef enum logic [7:0]
    {
        OPC_WRITE = 8'h02,
        OPC_READ  = 8'h03,
        OPC_RDSR  = 8'h05,
        OPC_WREN  = 8'h06
    } spiOpcode_t;

    localparam int STATUS_WEL    = 1; // write enable latch
    localparam int BITS_PER_BYTE = 8;

endpackage

`default_nettype wire

/* hw/eepromSequencer.sv */
// Command sequencer for a 25xx style SPI EEPROM with 8-bit addresses.
// A start pulse while idle latches req, addr and wrData and runs one of
//   read   : READ opcode, address, one byte received into rdData
//   write  : WREN, chip select gap, WRITE opcode, address, data
//   status : RDSR opcode, one status byte received into rdData
// busy rises on the edge after start, done pulses once at the end.
// Bytes move over spiByteIf to the SPI engine.

`timescale 1ns/10ps
`default_nettype none

module eepromSequencer
    import eepromPkg::*;
(
    input  logic         CLOCK,
    input  logic         RST_n,
    input  logic         start,
    input  eepromReq_t   req,
    input  logic [7:0]   addr,
    input  logic [7:0]   wrData,
    output logic         busy,
    output logic         done,
    output logic [7:0]   rdData,
    spiByteIf.seqSide    link
);

    typedef enum logic [2:0]
    {
        IDLE,
        SEND_WREN,
        CS_GAP,
        SEND_OPC,
        SEND_ADDR,
        SEND_DATA,
        RECV,
        FINISH
    } seqState_t;

    seqState_t  state;
    eepromReq_t reqQ;
    logic [7:0] addrQ;
    logic [7:0] dataQ;
    logic       gapCnt; // second clock of the CS gap
    logic       accept;

    assign accept = (state == IDLE) && start && !busy;

    // operands held for the whole request
    always_ff @(posedge CLOCK)
    begin
        if (accept)
        begin
            reqQ  <= req;
            addrQ <= addr;
            dataQ <= wrData;
        end
    end

    // byte on offer follows the state, so it is ready one clock
    // before the engine picks up bit 7
    always_comb
    begin
        case (state)
            SEND_WREN: link.txData = OPC_WREN;
            SEND_OPC:
            begin
                case (reqQ)
                    REQ_WRITE:  link.txData = OPC_WRITE;
                    REQ_STATUS: link.txData = OPC_RDSR;
                    default:    link.txData = OPC_READ;
                endcase
            end
            SEND_ADDR: link.txData = addrQ;
            SEND_DATA: link.txData = dataQ;
            default:   link.txData = 8'h00;
        endcase
    end

    always_ff @(posedge CLOCK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            state     <= IDLE;
            busy      <= 1'b0;
            done      <= 1'b0;
            rdData    <= 8'd0;
            gapCnt    <= 1'b0;
            link.txEn <= 1'b0;
            link.rxEn <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                IDLE:
                begin
                    busy <= 1'b0;
                    if (accept)
                    begin
                        busy      <= 1'b1;
                        link.txEn <= 1'b1;
                        state     <= (req == REQ_WRITE) ? SEND_WREN : SEND_OPC;
                    end
                end
                SEND_WREN:
                begin
                    if (link.txDone)
                    begin
                        link.txEn <= 1'b0; // CS must rise to latch WREN
                        gapCnt    <= 1'b0;
                        state     <= CS_GAP;
                    end
                end
                CS_GAP:
                begin
                    if (gapCnt)
                    begin
                        link.txEn <= 1'b1;
                        state     <= SEND_OPC;
                    end
                    else
                        gapCnt <= 1'b1;
                end
                SEND_OPC:
                begin
                    if (link.txDone)
                    begin
                        if (reqQ == REQ_STATUS)
                        begin
                            link.txEn <= 1'b0; // hand over without a CS break
                            link.rxEn <= 1'b1;
                            state     <= RECV;
                        end
                        else
                            state <= SEND_ADDR;
                    end
                end
                SEND_ADDR:
                begin
                    if (link.txDone)
                    begin
                        if (reqQ == REQ_WRITE)
                            state <= SEND_DATA;
                        else
                        begin
                            link.txEn <= 1'b0;
                            link.rxEn <= 1'b1;
                            state     <= RECV;
                        end
                    end
                end
                SEND_DATA:
                begin
                    if (link.txDone)
                    begin
                        link.txEn <= 1'b0;
                        state     <= FINISH;
                    end
                end
                RECV:
                begin
                    if (link.rxDone)
                    begin
                        rdData    <= link.rxData;
                        link.rxEn <= 1'b0;
                        state     <= FINISH;
                    end
                end
                FINISH:
                begin
                    done  <= 1'b1; // busy drops on the following edge
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    enablesExclusive: assert property (
        @(posedge CLOCK) disable iff (!RST_n)
        !(link.txEn && link.rxEn)
    );

    doneWhileBusy: assert property (
        @(posedge CLOCK) disable iff (!RST_n)
        done |-> busy
    );

endmodule

`default_nettype wire

/* hw/spiByteEngine.sv */
// Byte serial SPI master, clock idles low, MISO sampled as SCK rises.
// While txEn is high it shifts link.txData out MSB first, one byte per
// 16 clocks, and pulses txDone in the 15th cycle of each byte.
// While rxEn is high it shifts a byte in and pulses rxDone after the
// 16th edge. txEn wins over rxEn. Chip select stays low while either
// enable is high and everything drops back to idle once both are low.

`timescale 1ns/10ps
`default_nettype none

module spiByteEngine
    import eepromPkg::*;
(
    input  logic          CLOCK,
    input  logic          RST_n,
    spiByteIf.engineSide  link,
    input  logic          spiMiso,
    output logic          spiSck,
    output logic          spiCsN,
    output logic          spiMosi
);

    logic [3:0] txPhase; // even drives MOSI, odd raises SCK
    logic [3:0] rxPhase;
    logic [2:0] txBit;
    logic [2:0] rxBit;

    // phase pairs walk the byte from bit 7 down to bit 0
    assign txBit = 3'(BITS_PER_BYTE - 1) - txPhase[3:1];
    assign rxBit = 3'(BITS_PER_BYTE - 1) - rxPhase[3:1];

    always_ff @(posedge CLOCK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            txPhase     <= 4'd0;
            rxPhase     <= 4'd0;
            spiCsN      <= 1'b1;
            spiSck      <= 1'b0;
            spiMosi     <= 1'b0;
            link.txDone <= 1'b0;
            link.rxDone <= 1'b0;
            link.rxData <= 8'd0;
        end
        else if (link.txEn)
        begin
            spiCsN      <= 1'b0;
            rxPhase     <= 4'd0;
            link.rxDone <= 1'b0;
            txPhase     <= txPhase + 4'd1; // wraps into the next byte
            if (txPhase[0])
            begin
                spiSck      <= 1'b1;
                link.txDone <= 1'b0;
            end
            else
            begin
                spiSck      <= 1'b0;
                spiMosi     <= link.txData[txBit];
                link.txDone <= (txPhase == 4'(2 * BITS_PER_BYTE - 2)); // bit 0 going out
            end
        end
        else if (link.rxEn)
        begin
            spiCsN      <= 1'b0;
            txPhase     <= 4'd0;
            link.txDone <= 1'b0;
            rxPhase     <= rxPhase + 4'd1;
            if (rxPhase[0])
            begin
                spiSck              <= 1'b1;
                link.rxData[rxBit]  <= spiMiso;
                link.rxDone         <= (rxPhase == 4'(2 * BITS_PER_BYTE - 1));
            end
            else
            begin
                spiSck      <= 1'b0; // slave shifts on this fall
                link.rxDone <= 1'b0;
            end
        end
        else
        begin
            txPhase     <= 4'd0;
            rxPhase     <= 4'd0;
            spiCsN      <= 1'b1;
            spiSck      <= 1'b0;
            spiMosi     <= 1'b0;
            link.txDone <= 1'b0;
            link.rxDone <= 1'b0;
            link.rxData <= 8'd0;
        end
    end

    // a clock pulse outside a frame would corrupt the slave
    sckOnlyInFrame: assert property (
        @(posedge CLOCK) disable iff (!RST_n)
        spiCsN |-> !spiSck
    );

    doneExclusive: assert property (
        @(posedge CLOCK) disable iff (!RST_n)
        !(link.txDone && link.rxDone)
    );

endmodule

`default_nettype wire

/* hw/spiByteIf.sv */
// Byte level link between the command sequencer and the SPI engine.
// The sequencer holds txEn or rxEn for as long as the transaction runs
// and the engine answers with one cycle done pulses per byte.

`timescale 1ns/10ps
`default_nettype none

interface spiByteIf;

    logic       txEn;   // level, send while high
    logic       rxEn;   // level, receive while high
    logic [7:0] txData;
    logic       txDone; // pulse, last bit on MOSI
    logic       rxDone; // pulse, byte captured
    logic [7:0] rxData;

    modport seqSide
    (
        output txEn, rxEn, txData,
        input  txDone, rxDone, rxData
    );

    modport engineSide
    (
        input  txEn, rxEn, txData,
        output txDone, rxDone, rxData
    );

endinterface

`default_nettype wire

/* hw/spiEepromCtrl.sv */
// Top level of the SPI EEPROM controller.
// Host side takes a one cycle start with req, addr and wrData and
// reports busy, done and rdData. SPI side drives a single 25xx part
// in mode 0. The sequencer feeds the byte engine over spiByteIf.

`timescale 1ns/10ps
`default_nettype none

module spiEepromCtrl
    import eepromPkg::*;
(
    input  logic       CLOCK,
    input  logic       RST_n,
    input  logic       start,
    input  logic [1:0] req,
    input  logic [7:0] addr,
    input  logic [7:0] wrData,
    output logic       busy,
    output logic       done,
    output logic [7:0] rdData,
    input  logic       spiMiso,
    output logic       spiSck,
    output logic       spiCsN,
    output logic       spiMosi
);

    spiByteIf link();

    eepromSequencer eepromSequencer_i
    (
        .CLOCK  (CLOCK),
        .RST_n  (RST_n),
        .start  (start),
        .req    (eepromReq_t'(req)), // 2'd3 is handled as a read
        .addr   (addr),
        .wrData (wrData),
        .busy   (busy),
        .done   (done),
        .rdData (rdData),
        .link   (link.seqSide)
    );

    spiByteEngine spiByteEngine_i
    (
        .CLOCK   (CLOCK),
        .RST_n   (RST_n),
        .link    (link.engineSide),
        .spiMiso (spiMiso),
        .spiSck  (spiSck),
        .spiCsN  (spiCsN),
        .spiMosi (spiMosi)
    );

endmodule

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# Exits non-zero unless the simulation reports a clean run.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tbSpiEepromCtrl -f spiEepromCtrl.f -o simv

out=$(./obj_dir/simv || true)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* spiEepromCtrl.f */
hw/eepromPkg.sv
hw/spiByteIf.sv
hw/spiByteEngine.sv
hw/eepromSequencer.sv
hw/spiEepromCtrl.sv
test/eepromModel.sv
test/tbSpiEepromCtrl.sv

/* test/eepromModel.sv */
// Behavioral 25xx SPI EEPROM with 256 bytes and 8-bit addresses.
// Reads MOSI on the rising SCK edge and shifts MISO out on the falling edge.
// Understands WREN, WRITE, READ and RDSR. WEL and a pending write take
// effect when chip select rises, as on the real part.

`timescale 1ns/10ps
`default_nettype none

module eepromModel
    import eepromPkg::*;
(
    input  logic spiSck,
    input  logic spiCsN,
    input  logic spiMosi,
    output logic spiMiso
);

    logic [7:0] mem [256];
    logic       wel;
    logic [2:0] bitCnt;
    logic [1:0] byteIdx;   // saturates, later bytes are ignored
    logic [7:0] shiftIn;
    logic [7:0] opcode;
    logic [7:0] addrQ;
    logic [7:0] dataQ;
    logic       dataFull;
    logic [7:0] outByte;
    logic       outMode;
    logic [2:0] outCnt;

    initial
    begin
        for (int i = 0; i < 256; i++)
            mem[i] = 8'hFF;
        wel      = 1'b0;
        bitCnt   = 3'd0;
        byteIdx  = 2'd0;
        shiftIn  = 8'h00;
        opcode   = 8'h00;
        addrQ    = 8'h00;
        dataQ    = 8'h00;
        dataFull = 1'b0;
        outByte  = 8'h00;
        outMode  = 1'b0;
        outCnt   = 3'd0;
        spiMiso  = 1'b0;
    end

    always @(posedge spiSck or posedge spiCsN)
    begin
        logic [7:0] byteNow;
        logic [7:0] statusByte;
        if (spiCsN)
        begin
            if (opcode == OPC_WREN && byteIdx != 2'd0)
                wel <= 1'b1;
            else if (opcode == OPC_WRITE && dataFull)
            begin
                if (wel)
                    mem[addrQ] <= dataQ;
                wel <= 1'b0; // cleared whether or not the write happened
            end
            bitCnt   <= 3'd0;
            byteIdx  <= 2'd0;
            outMode  <= 1'b0;
            dataFull <= 1'b0;
        end
        else
        begin
            byteNow    = {shiftIn[6:0], spiMosi};
            statusByte = 8'h00;
            statusByte[STATUS_WEL] = wel;
            shiftIn <= byteNow;
            bitCnt  <= bitCnt + 3'd1;
            if (bitCnt == 3'(BITS_PER_BYTE - 1))
            begin
                if (byteIdx != 2'd3)
                    byteIdx <= byteIdx + 2'd1;
                case (byteIdx)
                    2'd0:
                    begin
                        opcode <= byteNow;
                        if (byteNow == OPC_RDSR)
                        begin
                            outByte <= statusByte;
                            outMode <= 1'b1;
                        end
                    end
                    2'd1:
                    begin
                        addrQ <= byteNow;
                        if (opcode == OPC_READ)
                        begin
                            outByte <= mem[byteNow];
                            outMode <= 1'b1;
                        end
                    end
                    2'd2:
                    begin
                        if (opcode == OPC_WRITE)
                        begin
                            dataQ    <= byteNow;
                            dataFull <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // MSB goes out on the first fall after the command bytes
    always @(negedge spiSck)
    begin
        if (!outMode)
            outCnt <= 3'd0;
        else
        begin
            spiMiso <= outByte[3'd7 - outCnt];
            outCnt  <= outCnt + 3'd1;
        end
    end

endmodule

`default_nettype wire

/* test/tbSpiEepromCtrl.sv */
// Testbench for the SPI EEPROM controller.
// Runs host requests through the DUT against a behavioral 25xx model on
// the SPI pins. A shadow array predicts read data, concurrent assertions
// check values, framing and the busy/done protocol. One line per test,
// then a summary line and the final verdict.

`timescale 1ns/10ps
`default_nettype none

module tbSpiEepromCtrl
    import eepromPkg::*;
();

    localparam int CLK_PERIOD  = 10;
    localparam int SEED        = 63520;
    localparam int NUM_TESTS   = 24;
    localparam int DONE_WAIT   = 300; // clocks before a request counts as hung
    localparam int WATCHDOG_NS = (NUM_TESTS * 200 + 1000) * CLK_PERIOD;

    logic        CLOCK;
    logic        RST_n;
    logic        start;
    logic [1:0]  req;
    logic [7:0]  addr;
    logic [7:0]  wrData;
    logic        busy;
    logic        done;
    logic [7:0]  rdData;
    logic        spiMiso;
    logic        spiSck;
    logic        spiCsN;
    logic        spiMosi;

    logic [7:0]  shadow [256];
    string       testName;
    int          errorCount = 0;
    int          testErrors = 0;
    int          passCount = 0;
    int          failCount = 0;
    logic        checkReset;
    logic        expectRead;
    logic [7:0]  expData;
    logic        reqOpen;    // a request is outstanding

    spiEepromCtrl spiEepromCtrl_i
    (
        .CLOCK   (CLOCK),
        .RST_n   (RST_n),
        .start   (start),
        .req     (req),
        .addr    (addr),
        .wrData  (wrData),
        .busy    (busy),
        .done    (done),
        .rdData  (rdData),
        .spiMiso (spiMiso),
        .spiSck  (spiSck),
        .spiCsN  (spiCsN),
        .spiMosi (spiMosi)
    );

    eepromModel eepromModel_i
    (
        .spiSck  (spiSck),
        .spiCsN  (spiCsN),
        .spiMosi (spiMosi),
        .spiMiso (spiMiso)
    );

    initial
    begin
        CLOCK = 1'b0;
        forever #(CLK_PERIOD / 2) CLOCK = ~CLOCK;
    end

    task automatic reportValue(input logic [7:0] expected, input logic [7:0] actual);
        errorCount++;
        $display("[FAIL] %s expected %02h actual %02h", testName, expected, actual);
    endtask

    task automatic reportError(input string what);
        errorCount++;
        $display("%s: %s", testName, what);
    endtask

    task automatic beginTest(input string name);
        testName   = name;
        testErrors = errorCount;
    endtask

    task automatic endTest();
        if (errorCount == testErrors)
        begin
            passCount++;
            $display("[PASS] %s", testName);
        end
        else
        begin
            failCount++;
            $display("%s ended with %0d failed checks", testName, errorCount - testErrors);
        end
    endtask

    task automatic issueRequest(input eepromReq_t kind, input logic [7:0] a,
                                input logic [7:0] d);
        req     = kind;
        addr    = a;
        wrData  = d;
        start   = 1'b1;
        reqOpen = 1'b1;
        @(posedge CLOCK);
        #1;
        start   = 1'b0;
    endtask

    // returns one clock after done so busy has dropped
    task automatic waitDone();
        int cycles;
        cycles = 0;
        while (!done && cycles < DONE_WAIT)
        begin
            @(posedge CLOCK);
            #1;
            cycles++;
        end
        if (!done)
            reportError("no done pulse came back for the request");
        else
        begin
            @(posedge CLOCK);
            #1;
        end
        reqOpen = 1'b0;
    endtask

    task automatic writeByte(input logic [7:0] a, input logic [7:0] d);
        expectRead = 1'b0;
        issueRequest(REQ_WRITE, a, d);
        waitDone();
        shadow[a] = d;
    endtask

    task automatic readByte(input logic [7:0] a);
        expectRead = 1'b1;
        expData    = shadow[a];
        issueRequest(REQ_READ, a, 8'h00);
        waitDone();
    endtask

    resetState: assert property (
        @(posedge CLOCK) checkReset |-> (spiCsN && !spiSck && !busy && !done)
    ) else reportError("outputs not idle during or right after reset");

    readValue: assert property (
        @(posedge CLOCK) disable iff (!RST_n)
        (done && expectRead) |-> (rdData == expData)
    ) else reportValue(expData, rdData);

    sckInFrame: assert property (
        @(posedge CLOCK) disable iff (!RST_n) spiSck |-> !spiCsN
    ) else reportError("SCK high while chip select is high");

    csBeforeSck: assert property (
        @(posedge CLOCK) disable iff (!RST_n) $rose(spiSck) |-> $past(!spiCsN)
    ) else reportError("SCK rose before chip select went low");

    busyOnStart: assert property (
        @(posedge CLOCK) disable iff (!RST_n) (start && !busy) |=> busy
    ) else reportError("busy did not rise after start");

    busyUntilDone: assert property (
        @(posedge CLOCK) disable iff (!RST_n) (busy && !done) |=> busy
    ) else reportError("busy dropped before done");

    doneSingle: assert property (
        @(posedge CLOCK) disable iff (!RST_n) done |=> !done
    ) else reportError("done stayed high for more than one clock");

    doneForRequest: assert property (
        @(posedge CLOCK) disable iff (!RST_n) done |-> reqOpen
    ) else reportError("done pulse without an outstanding request");

    initial
    begin
        logic [7:0] a;
        logic [7:0] d;
        void'($urandom(SEED));
        for (int i = 0; i < 256; i++)
            shadow[i] = 8'hFF;
        RST_n      = 1'b0;
        start      = 1'b0;
        req        = 2'd0;
        addr       = 8'h00;
        wrData     = 8'h00;
        checkReset = 1'b0;
        expectRead = 1'b0;
        expData    = 8'h00;
        reqOpen    = 1'b0;

        beginTest("reset state");
        @(posedge CLOCK);
        #1;
        checkReset = 1'b1;
        repeat (7) @(posedge CLOCK);
        #1;
        RST_n = 1'b1;
        repeat (2) @(posedge CLOCK);
        #1;
        checkReset = 1'b0;
        endTest();

        beginTest("read unwritten");
        readByte(8'($urandom()));
        endTest();

        for (int n = 0; n < 20; n++)
        begin
            a = 8'($urandom());
            d = 8'($urandom());
            beginTest($sformatf("write/read %0d at %02h", n, a));
            writeByte(a, d);
            readByte(a);
            endTest();
        end

        beginTest("status after write");
        writeByte(8'($urandom()), 8'($urandom()));
        expectRead = 1'b1;
        expData    = 8'h00; // WEL cleared by the write
        issueRequest(REQ_STATUS, 8'h00, 8'h00);
        waitDone();
        endTest();

        beginTest("start while busy");
        a = 8'($urandom());
        d = 8'($urandom());
        expectRead = 1'b0;
        issueRequest(REQ_WRITE, a, d);
        repeat (20) @(posedge CLOCK);
        #1;
        addr   = a ^ 8'h80;
        wrData = ~d;
        start  = 1'b1;
        @(posedge CLOCK);
        #1;
        start  = 1'b0;
        waitDone();
        shadow[a] = d;
        repeat (80) @(posedge CLOCK); // room for a stray second done
        #1;
        readByte(a ^ 8'h80);
        readByte(a);
        endTest();

        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (errorCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
